// ==== div_unit_pkg.sv ====
package div_unit_pkg;

	// dividend and quotient width
	localparam int DIVIDEND_W = 16;

	// divisor width, remainder fits here too
	localparam int DIVISOR_W = 8;

	// quotient bits resolved per iteration
	localparam int DIGIT_W = 4;

	// one digit per nibble of the dividend
	localparam int NUM_DIGITS = DIVIDEND_W / DIGIT_W;

	// radix of the long division, also the multiples table depth
	localparam int RADIX = 1 << DIGIT_W;

	// width of one table entry, 15 x 255 needs 12 bits
	localparam int MULT_W = DIVISOR_W + DIGIT_W;

	// digit counter width in the core
	localparam int DIGIT_CNT_W = $clog2(NUM_DIGITS);

	// requested result word
	// quotient, or remainder zero-extended to DIVIDEND_W
	typedef enum logic
	{
		OP_QUO = 1'b0,
		OP_REM = 1'b1
	} div_op_e;

endpackage

// ==== div_cmd_if.sv ====
`timescale 1ns/1ps

// decoded command, decode stage to execute core
interface div_cmd_if
	import div_unit_pkg::*;
();

	logic                  valid;
	logic                  ready;
	div_op_e               op;
	logic [DIVIDEND_W-1:0] dividend;
	logic [DIVISOR_W-1:0]  divisor;
	// divisor was zero, flagged once in decode
	logic                  div_zero;

	// decode side
	modport src (output valid, output op, output dividend, output divisor,
		output div_zero, input ready);

	// execute side
	modport dst (input valid, input op, input dividend, input divisor,
		input div_zero, output ready);

endinterface

// ==== div_res_if.sv ====
`timescale 1ns/1ps

// raw quotient and remainder, execute core to result stage
interface div_res_if
	import div_unit_pkg::*;
();

	logic                  valid;
	logic                  ready;
	// op travels along so result can pick the word
	div_op_e               op;
	logic [DIVIDEND_W-1:0] quotient;
	logic [DIVISOR_W-1:0]  remainder;
	logic                  div_zero;

	// execute side
	modport src (output valid, output op, output quotient, output remainder,
		output div_zero, input ready);

	// result side
	modport dst (input valid, input op, input quotient, input remainder,
		input div_zero, output ready);

endinterface

// ==== div_decode.sv ====
`timescale 1ns/1ps

module div_decode
	import div_unit_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  div_op_e               in_op,
	input  logic [DIVIDEND_W-1:0] in_dividend,
	input  logic [DIVISOR_W-1:0]  in_divisor,
	div_cmd_if.src                cmd
);

	logic accept;

	// one entry, free when empty or draining this cycle
	assign in_ready = !cmd.valid || cmd.ready;
	assign accept = in_valid && in_ready;

	// valid bit of the command register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd.valid <= 1'b0;
		end
		else if (in_ready)
		begin
			// load on accept, else clear after transfer
			cmd.valid <= in_valid;
		end
	end

	// payload only moves on accept
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cmd.op       <= in_op;
			cmd.dividend <= in_dividend;
			cmd.divisor  <= in_divisor;
			// the only zero-divisor test in the design
			cmd.div_zero <= (in_divisor == '0);
		end
	end

endmodule

// ==== div_radix16_core.sv ====
`timescale 1ns/1ps

module div_radix16_core
	import div_unit_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	div_cmd_if.dst cmd,
	div_res_if.src res
);

	enum logic [1:0]
	{
		ST_IDLE,
		ST_WORK,
		ST_DONE
	} state;

	// multiples 0..15 of the divisor
	logic [MULT_W-1:0]      mult_tbl [RADIX];
	logic [DIVISOR_W-1:0]   tbl_base;
	// dividend nibbles shift out at the top
	logic [DIVIDEND_W-1:0]  dividend_q;
	// quotient digits shift in at the bottom
	logic [DIVIDEND_W-1:0]  quotient_q;
	// partial remainder is always below the divisor
	logic [DIVISOR_W-1:0]   part_rem;
	logic [DIGIT_CNT_W-1:0] digit_cnt;
	div_op_e                op_q;
	logic                   zero_q;

	logic [MULT_W-1:0]      shifted;
	logic [DIGIT_W-1:0]     digit;
	logic [DIGIT_W-1:0]     cand;
	logic [MULT_W-1:0]      rem_diff;
	logic                   start;

	assign cmd.ready = (state == ST_IDLE);
	assign start = cmd.valid && cmd.ready;

	// zero divisor runs as 0 / 1 so both results come out 0
	assign tbl_base = cmd.div_zero ? DIVISOR_W'(1) : cmd.divisor;

	// bring down the next dividend nibble
	assign shifted = {part_rem, dividend_q[DIVIDEND_W-1 -: DIGIT_W]};

	// binary search for the largest multiple not above shifted
	// msb splits on 8x and three more levels narrow it down
	always_comb
	begin
		digit = '0;
		cand = '0;
		for (int b = DIGIT_W - 1; b >= 0; b--)
		begin
			cand = digit;
			cand[b] = 1'b1;
			if (mult_tbl[cand] <= shifted)
			begin
				digit = cand;
			end
		end
		rem_diff = shifted - mult_tbl[digit];
	end

	// control goes idle then four digit cycles then holds until taken
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			digit_cnt <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						state <= ST_WORK;
						// msb digit first
						digit_cnt <= DIGIT_CNT_W'(NUM_DIGITS - 1);
					end
				end
				ST_WORK:
				begin
					digit_cnt <= digit_cnt - DIGIT_CNT_W'(1);
					if (digit_cnt == '0)
					begin
						state <= ST_DONE;
					end
				end
				ST_DONE:
				begin
					if (res.ready)
					begin
						state <= ST_IDLE;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			for (int m = 0; m < RADIX; m++)
			begin
				mult_tbl[m] <= MULT_W'(tbl_base) * MULT_W'(m);
			end
			dividend_q <= cmd.div_zero ? '0 : cmd.dividend;
			part_rem <= '0;
			op_q <= cmd.op;
			zero_q <= cmd.div_zero;
		end
		else if (state == ST_WORK)
		begin
			dividend_q <= dividend_q << DIGIT_W;
			quotient_q <= {quotient_q[DIVIDEND_W-DIGIT_W-1:0], digit};
			// difference stays below the divisor
			part_rem <= rem_diff[DIVISOR_W-1:0];
		end
	end

	// after the last digit part_rem is the remainder
	assign res.valid = (state == ST_DONE);
	assign res.op = op_q;
	assign res.quotient = quotient_q;
	assign res.remainder = part_rem;
	assign res.div_zero = zero_q;

endmodule

// ==== div_result.sv ====
`timescale 1ns/1ps

module div_result
	import div_unit_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	div_res_if.dst                res,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [DIVIDEND_W-1:0] out_data,
	output logic                  out_div_zero
);

	logic take;

	// stalls the core while a result waits on out_ready
	assign res.ready = !out_valid || out_ready;
	assign take = res.valid && res.ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else if (res.ready)
		begin
			out_valid <= res.valid;
		end
	end

	// word select happens on the way in
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			if (res.op == OP_REM)
			begin
				// remainder zero-extended
				out_data <= DIVIDEND_W'(res.remainder);
			end
			else
			begin
				out_data <= res.quotient;
			end
			out_div_zero <= res.div_zero;
		end
	end

endmodule

// ==== div_unit_top.sv ====
`timescale 1ns/1ps

module div_unit_top
	import div_unit_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  div_op_e               in_op,
	input  logic [DIVIDEND_W-1:0] in_dividend,
	input  logic [DIVISOR_W-1:0]  in_divisor,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [DIVIDEND_W-1:0] out_data,
	output logic                  out_div_zero
);

	// decode to execute
	div_cmd_if cmd_if ();
	// execute to result
	div_res_if res_if ();

	// stage 1, command register
	div_decode div_decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_op       (in_op),
		.in_dividend (in_dividend),
		.in_divisor  (in_divisor),
		.cmd         (cmd_if.src)
	);

	// stage 2, four digit cycles per command
	div_radix16_core div_radix16_core_i (
		.clk   (clk),
		.rst_n (rst_n),
		.cmd   (cmd_if.dst),
		.res   (res_if.src)
	);

	// stage 3, output register
	div_result div_result_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.res          (res_if.dst),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_data     (out_data),
		.out_div_zero (out_div_zero)
	);

endmodule

// ==== tb_div_unit.sv ====
`timescale 1ns/1ps

module tb_div_unit
	import div_unit_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 4;
	localparam int NUM_QUO = 200;
	localparam int NUM_REM = 100;
	localparam int NUM_ZERO = 20;
	localparam int NUM_BOUND = 8;
	localparam int NUM_MIX = 150;
	// plus one isolated latency command
	localparam int NUM_CMDS = NUM_QUO + NUM_REM + NUM_ZERO + NUM_BOUND + NUM_MIX + 1;
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 40 + RST_CYCLES;
	// longest wait for the pipeline to empty
	localparam int DRAIN_CYCLES = 100;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	logic                  in_ready;
	div_op_e               in_op;
	logic [DIVIDEND_W-1:0] in_dividend;
	logic [DIVISOR_W-1:0]  in_divisor;
	logic                  out_valid;
	logic                  out_ready;
	logic [DIVIDEND_W-1:0] out_data;
	logic                  out_div_zero;

	int seed = 35160;
	int errors = 0;
	int sent = 0;
	int received = 0;
	int cycle = 0;
	int accept_cycle = 0;
	// random out_ready when set
	logic bp_on = 1'b0;
	// {div_zero, data} per accepted command
	logic [DIVIDEND_W:0] exp_q [$];
	logic [DIVIDEND_W:0] exp_word;

	div_unit_top div_unit_top_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_op        (in_op),
		.in_dividend  (in_dividend),
		.in_divisor   (in_divisor),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_data     (out_data),
		.out_div_zero (out_div_zero)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle++;
	end

	// expected word straight from unsigned division rules
	function automatic logic [DIVIDEND_W:0] div_ref(input div_op_e op,
		input logic [DIVIDEND_W-1:0] dvd, input logic [DIVISOR_W-1:0] dvs);
		if (dvs == '0)
		begin
			return {1'b1, 16'h0000};
		end
		else if (op == OP_QUO)
		begin
			return {1'b0, 16'(dvd / dvs)};
		end
		else
		begin
			return {1'b0, 16'(dvd % dvs)};
		end
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			$display("ERROR %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	// never zero for the plain quotient and remainder runs
	function automatic logic [DIVISOR_W-1:0] random_divisor();
		logic [DIVISOR_W-1:0] d;
		d = 8'($random(seed));
		if (d == '0)
		begin
			d = 8'h01;
		end
		return d;
	endfunction

	function automatic div_op_e random_op();
		return (($random(seed) & 1) != 0) ? OP_REM : OP_QUO;
	endfunction

	// called at posedge + 1 and returns at posedge + 1 after the accept edge
	task automatic send_cmd(input div_op_e op, input logic [DIVIDEND_W-1:0] dvd,
		input logic [DIVISOR_W-1:0] dvs);
		// random idle cycle between commands
		if (($random(seed) & 3) == 0)
		begin
			in_valid = 1'b0;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		in_op = op;
		in_dividend = dvd;
		in_divisor = dvs;
		// in_ready only depends on registers so it is stable here
		while (!in_ready)
		begin
			@(posedge clk);
			#1;
		end
		exp_q.push_back(div_ref(op, dvd, dvs));
		accept_cycle = cycle + 1;
		sent++;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	// bounded wait until every sent command has come back
	task automatic wait_drain();
		int waited = 0;
		while ((received < sent || out_valid) && waited < DRAIN_CYCLES)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	// out_ready is random only during the back-pressure run
	always @(posedge clk)
	begin
		#1;
		out_ready = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
	end

	// monitor looks at each transfer half a cycle before its edge
	always @(negedge clk)
	begin
		if (rst_n && out_valid && out_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("a result came out with no command pending");
				errors++;
			end
			else
			begin
				exp_word = exp_q.pop_front();
				check_val("out_data", 32'(exp_word[DIVIDEND_W-1:0]), 32'(out_data));
				check_val("out_div_zero", 32'(exp_word[DIVIDEND_W]), 32'(out_div_zero));
			end
			received++;
		end
	end

	initial
	begin
		logic [DIVIDEND_W-1:0] dvd;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_op = OP_QUO;
		in_dividend = '0;
		in_divisor = '0;
		out_ready = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// random quotients
		repeat (NUM_QUO) send_cmd(OP_QUO, 16'($random(seed)), random_divisor());

		// random remainders
		repeat (NUM_REM) send_cmd(OP_REM, 16'($random(seed)), random_divisor());

		// divide by zero with both ops and edge dividends first
		for (int i = 0; i < NUM_ZERO / 2; i++)
		begin
			dvd = (i == 0) ? 16'h0000 : (i == 1) ? 16'hffff : 16'($random(seed));
			send_cmd(OP_QUO, dvd, 8'h00);
			send_cmd(OP_REM, dvd, 8'h00);
		end

		// boundary operands
		send_cmd(OP_QUO, 16'hffff, 8'h01);
		send_cmd(OP_REM, 16'hffff, 8'h01);
		send_cmd(OP_QUO, 16'hffff, 8'hff);
		send_cmd(OP_REM, 16'hffff, 8'hff);
		// dividend below divisor
		send_cmd(OP_QUO, 16'h0012, 8'h40);
		send_cmd(OP_REM, 16'h0012, 8'h40);
		send_cmd(OP_QUO, 16'h0000, 8'h07);
		send_cmd(OP_REM, 16'h0000, 8'h07);
		wait_drain();

		// mixed stream under back-pressure with zero divisors allowed
		bp_on = 1'b1;
		repeat (NUM_MIX) send_cmd(random_op(), 16'($random(seed)), 8'($random(seed)));
		bp_on = 1'b0;
		wait_drain();

		// isolated command expects out_valid six edges after accept
		send_cmd(OP_QUO, 16'h1234, 8'h0d);
		while (!out_valid)
		begin
			@(posedge clk);
			#1;
		end
		check_val("latency", 32'd6, 32'(cycle - accept_cycle));
		wait_drain();

		check_val("result_count", 32'(sent), 32'(received));
		$display("results %0d of %0d, errors %0d", received, sent, errors);
		if (errors == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== div_unit.f ====
div_unit_pkg.sv
div_cmd_if.sv
div_res_if.sv
div_decode.sv
div_radix16_core.sv
div_result.sv
div_unit_top.sv
tb_div_unit.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_div_unit
FILELIST  = div_unit.f
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
